// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= axi_mem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/axi_mem_tb.sv ====
// Random burst testbench for the AXI burst memory slave
// Memory is filled first, since the RTL word array has no reset value
// There is no B channel, so writes are checked by reading them back
`timescale 1ns/1ns
`default_nettype none

module axi_mem_tb
	import axi_mem_pkg::*;
();

	localparam int NUM_ROUNDS       = 36;
	localparam int MAX_BURSTS       = 300;
	localparam int CYCLES_PER_BURST = 80;
	localparam int TIMEOUT_CYCLES   = MAX_BURSTS * CYCLES_PER_BURST;

	logic clk = 1'b0;
	logic resetn;
	logic awvalid, awready, wvalid, wready, wlast, arvalid, arready;
	logic rvalid, rready, rlast;
	logic [ADDR_W-1:0] awaddr, araddr;
	logic [2:0] awsize, arsize;
	logic [1:0] awburst, arburst, rresp;
	axi_id_t awid, wid, arid, rid;
	axi_len_t awlen, arlen;
	axi_data_t wdata, rdata;
	axi_strb_t wstrb;

	logic [31:0] rng_state = 32'd676;
	axi_data_t model_mem [MEM_WORDS];
	rbeat_t exp_q [$];                 // Expected R beats in order
	logic [1:0] rd_burst [16];
	logic [2:0] rd_size [16];
	axi_len_t rd_len [16];
	logic [31:0] rd_addr [16];
	axi_id_t rd_id [16];
	int n_errors = 0;
	int n_checks = 0;
	int cycles = 0;

	axi_mem_top UUT (
		.clk, .resetn,
		.awvalid, .awready, .awaddr, .awsize, .awburst, .awid, .awlen,
		.wvalid, .wready, .wlast, .wdata, .wstrb, .wid,
		.arvalid, .arready, .araddr, .arsize, .arburst, .arid, .arlen,
		.rvalid, .rready, .rlast, .rdata, .rresp, .rid
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic axi_data_t fill_word(input mem_idx_t idx);
		return {idx ^ 8'hA5, idx, ~idx, idx ^ 8'h3C};
	endfunction

	// Unaligned start or more than 4 bytes per beat
	function automatic logic is_error(input logic [31:0] addr, input logic [2:0] size);
		return (addr[1:0] != 2'b00) || (size > 3'd2);
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// AW goes first and the model takes each W beat as it is accepted
	task automatic write_burst(input logic [1:0] burst, input logic [2:0] size,
			input axi_len_t len, input logic [31:0] addr, input logic fill);
		logic [31:0] a;
		logic [31:0] r;
		logic err;
		axi_id_t id;
		axi_data_t d;
		axi_strb_t s;
		mem_idx_t idx;
		int b;
		int lane;
		a = addr;
		err = is_error(addr, size);
		r = next_rand();
		id = r[3:0];
		awvalid = 1'b1;
		awaddr = addr;
		awsize = size;
		awburst = burst;
		awid = id;
		awlen = len;
		while (!awready) @(negedge clk);
		@(negedge clk);
		awvalid = 1'b0;
		for (b = 0; b <= int'(len); b++) begin
			r = next_rand();
			idx = a[9:2];
			d = fill ? fill_word(idx) : next_rand();
			s = fill ? 4'hF : r[3:0];
			if (r[7:6] == 2'b00)
				@(negedge clk);    // Idle gap on W
			wvalid = 1'b1;
			wdata = d;
			wstrb = s;
			wlast = (b == int'(len));
			wid = id;
			while (!wready) @(negedge clk);
			@(negedge clk);
			wvalid = 1'b0;
			if (!err) begin
				for (lane = 0; lane < STRB_W; lane++)
					if (s[lane])
						model_mem[idx][8*lane +: 8] = d[8*lane +: 8];
			end
			if (burst != BURST_FIXED)
				a = a + (32'd1 << size);
		end
	endtask

	// Expected beats come from the model when the AR goes out
	task automatic issue_read(input logic [1:0] burst, input logic [2:0] size,
			input axi_len_t len, input logic [31:0] addr, input axi_id_t id);
		logic [31:0] a;
		logic err;
		mem_idx_t idx;
		int b;
		a = addr;
		err = is_error(addr, size);
		for (b = 0; b <= int'(len); b++) begin
			idx = a[9:2];
			exp_q.push_back({b == int'(len), id, err ? RESP_SLVERR : RESP_OKAY,
				err ? 32'h0 : model_mem[idx]});
			if (burst != BURST_FIXED)
				a = a + (32'd1 << size);
		end
		arvalid = 1'b1;
		araddr = addr;
		arsize = size;
		arburst = burst;
		arid = id;
		arlen = len;
		while (!arready) @(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
	endtask

	task automatic collect_beats(input int total, input logic heavy_bp);
		int got;
		logic held;
		logic [31:0] r;
		rbeat_t prev;
		rbeat_t cur;
		rbeat_t exp;
		got = 0;
		held = 1'b0;
		prev = '0;
		while (got < total) begin
			cur = {rlast, rid, rresp, rdata};
			if (held) begin    // R must not move while stalled
				check_value("r_hold_valid", 64'(1'b1), 64'(rvalid));
				check_value("r_hold_beat", 64'(prev), 64'(cur));
			end
			r = next_rand();
			rready = heavy_bp ? (r[1:0] == 2'b00) : (r[1:0] != 2'b00);
			if (rvalid && rready) begin
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("R beat arrived with no read outstanding");
				end else begin
					exp = exp_q.pop_front();
					check_value("r_data", 64'(exp[31:0]), 64'(rdata));
					check_value("r_resp", 64'(exp[33:32]), 64'(rresp));
					check_value("r_id", 64'(exp[37:34]), 64'(rid));
					check_value("r_last", 64'(exp[38]), 64'(rlast));
				end
				got++;
				held = 1'b0;
			end else begin
				held = rvalid;
				prev = cur;
			end
			@(negedge clk);
		end
		rready = 1'b0;
	endtask

	task automatic run_reads(input int count, input logic heavy_bp);
		logic [31:0] r;
		int total;
		int k;
		total = 0;
		for (k = 0; k < count; k++) begin
			r = next_rand();
			rd_id[k] = r[3:0];
			total += int'(rd_len[k]) + 1;
		end
		fork
			begin
				for (k = 0; k < count; k++)
					issue_read(rd_burst[k], rd_size[k], rd_len[k], rd_addr[k], rd_id[k]);
			end
			collect_beats(total, heavy_bp);
		join
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		int i;
		int k;
		resetn = 1'b0;
		{awvalid, wvalid, arvalid, rready, wlast} = '0;
		{awaddr, awsize, awburst, awid, awlen} = '0;
		{wdata, wstrb, wid} = '0;
		{araddr, arsize, arburst, arid, arlen} = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		check_value("reset_rvalid", 64'(1'b0), 64'(rvalid));
		check_value("reset_awready", 64'(1'b1), 64'(awready));
		check_value("reset_wready", 64'(1'b1), 64'(wready));
		check_value("reset_arready", 64'(1'b1), 64'(arready));

		// Fill every word, then read it all back
		for (i = 0; i < 16; i++) begin
			write_burst(BURST_INCR, 3'd2, 4'hF, 32'(i) << 6, 1'b1);
			rd_burst[i] = BURST_INCR;
			rd_size[i] = 3'd2;
			rd_len[i] = 4'hF;
			rd_addr[i] = 32'(i) << 6;
		end
		run_reads(16, 1'b0);

		for (i = 0; i < NUM_ROUNDS; i++) begin
			for (k = 0; k < 4; k++) begin
				r = next_rand();
				r2 = next_rand();
				rd_burst[k] = (r[1:0] == 2'd3) ? BURST_INCR : r[1:0];
				rd_size[k] = (r[3:2] == 2'd3) ? 3'd2 : {1'b0, r[3:2]};
				rd_len[k] = r[7:4];
				rd_addr[k] = {r2[31:2], 2'b00};
				if (k == 3 || r[10:8] == 3'd0) begin    // Error request
					if (r[11])
						rd_size[k] = 3'd3;
					else
						rd_addr[k][1:0] = r[13:12] | 2'b01;
				end
				if (k < 3) begin
					write_burst(rd_burst[k], rd_size[k], rd_len[k], rd_addr[k], 1'b0);
					rd_addr[k][1:0] = 2'b00;    // Read back clean
					if (rd_size[k] > 3'd2)
						rd_size[k] = 3'd2;
				end
			end
			run_reads(4, i[0]);
		end

		repeat (4) @(negedge clk);
		check_value("end_rvalid", 64'(1'b0), 64'(rvalid));
		check_value("end_beats_left", 64'(0), 64'(exp_q.size()));
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/axi_mem_pkg.sv
verilog/sync_fifo.sv
verilog/axi_decoder.sv
verilog/burst_mem_engine.sv
verilog/axi_mem_top.sv
dv/axi_mem_tb.sv

// ==== verilog/axi_decoder.sv ====
// AXI front end that turns AW, AR and W beats into records pushed one cycle
// after the handshake, with R taken combinationally off the read-beat FIFO head
// Only address bits 15:0 travel in a request record
`timescale 1ns/1ns
`default_nettype none

module axi_decoder
	import axi_mem_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              resetn,
	// Write address
	input  wire logic              awvalid,
	output logic                   awready,
	input  wire logic [ADDR_W-1:0] awaddr,
	input  wire logic [2:0]        awsize,
	input  wire logic [1:0]        awburst,
	input  wire axi_id_t           awid,
	input  wire axi_len_t          awlen,
	// Write data
	input  wire logic              wvalid,
	output logic                   wready,
	input  wire logic              wlast,
	input  wire axi_data_t         wdata,
	input  wire axi_strb_t         wstrb,
	input  wire axi_id_t           wid,
	// Read address
	input  wire logic              arvalid,
	output logic                   arready,
	input  wire logic [ADDR_W-1:0] araddr,
	input  wire logic [2:0]        arsize,
	input  wire logic [1:0]        arburst,
	input  wire axi_id_t           arid,
	input  wire axi_len_t          arlen,
	// Read data
	output logic                   rvalid,
	input  wire logic              rready,
	output logic                   rlast,
	output axi_data_t              rdata,
	output logic [1:0]             rresp,
	output axi_id_t                rid,
	// FIFO side
	output logic                   aw_cntl_wr_req,
	output cntl_t                  aw_cntl_wr_din,
	input  wire logic              aw_cntl_full,
	output logic                   ar_cntl_wr_req,
	output cntl_t                  ar_cntl_wr_din,
	input  wire logic              ar_cntl_full,
	output logic                   w_data_wr_req,
	output wbeat_t                 w_data_wr_din,
	input  wire logic              w_data_full,
	output logic                   r_data_rd_req,
	input  wire rbeat_t            r_data_rd_dout,
	input  wire logic              r_data_empty
);

	logic aw_err;
	logic ar_err;
	logic aw_hs;
	logic ar_hs;
	logic w_hs;

	// Unaligned start or more than 4 bytes per beat
	assign aw_err = (awaddr[1:0] != 2'b00) || (awsize > 3'd2);
	assign ar_err = (araddr[1:0] != 2'b00) || (arsize > 3'd2);

	assign awready = !aw_cntl_full;
	assign arready = !ar_cntl_full;
	assign wready  = !w_data_full;

	assign aw_hs = awvalid && awready;
	assign ar_hs = arvalid && arready;
	assign w_hs  = wvalid && wready;

	// ------------------------------------------------------------
	// Request and write-beat pushes
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			aw_cntl_wr_req <= 1'b0;
			ar_cntl_wr_req <= 1'b0;
			w_data_wr_req  <= 1'b0;
		end else begin
			aw_cntl_wr_req <= aw_hs;
			ar_cntl_wr_req <= ar_hs;
			w_data_wr_req  <= w_hs;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			aw_cntl_wr_din <= {aw_err, awid, awburst, awsize, awlen, awaddr[15:0]};
		if (ar_hs)
			ar_cntl_wr_din <= {ar_err, arid, arburst, arsize, arlen, araddr[15:0]};
		if (w_hs)
			w_data_wr_din <= {wlast, wid, wstrb, wdata};
	end

	// ------------------------------------------------------------
	// R channel straight off the FIFO head
	// ------------------------------------------------------------
	assign rvalid = !r_data_empty;
	assign rlast  = rvalid && r_data_rd_dout[38];
	assign rid    = rvalid ? r_data_rd_dout[37:34] : '0;
	assign rresp  = rvalid ? r_data_rd_dout[33:32] : RESP_OKAY;
	assign rdata  = rvalid ? r_data_rd_dout[31:0] : '0;

	assign r_data_rd_req = rvalid && rready;    // Pop on handshake

	// A stalled R beat holds until the master takes it
	a_r_hold: assert property (@(posedge clk) disable iff (!resetn)
		rvalid && !rready |=> rvalid && $stable(r_data_rd_dout));

endmodule

`default_nettype wire

// ==== verilog/axi_mem_pkg.sv ====
// Shared widths, record layouts and engine states for the AXI burst memory
// Record fields are packed MSB first, so slice positions here must match
// the decoder and the engine
`default_nettype none

package axi_mem_pkg;

	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int STRB_W     = 4;
	localparam int CNTL_W     = 30;    // err, id, burst, size, len, addr[15:0]
	localparam int WBEAT_W    = 41;    // last, wid, strb, data
	localparam int RBEAT_W    = 39;    // last, rid, resp, data
	localparam int MEM_WORDS  = 256;
	localparam int MEM_IDX_W  = 8;
	localparam int CNTL_DEPTH = 4;
	localparam int DATA_DEPTH = 8;

	// Response codes
	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// Burst types where WRAP runs as INCR
	localparam logic [1:0] BURST_FIXED = 2'd0;
	localparam logic [1:0] BURST_INCR  = 2'd1;
	localparam logic [1:0] BURST_WRAP  = 2'd2;

	typedef logic [DATA_W-1:0]    axi_data_t;
	typedef logic [STRB_W-1:0]    axi_strb_t;
	typedef logic [3:0]           axi_id_t;
	typedef logic [3:0]           axi_len_t;     // Beats minus one
	typedef logic [CNTL_W-1:0]    cntl_t;
	typedef logic [WBEAT_W-1:0]   wbeat_t;
	typedef logic [RBEAT_W-1:0]   rbeat_t;
	typedef logic [MEM_IDX_W-1:0] mem_idx_t;     // Address bits 9:2

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_WRITE,
		ENG_READ
	} eng_state_t;

endpackage

`default_nettype wire

// ==== verilog/axi_mem_top.sv ====
// AXI3-style burst memory slave without a B channel
// Writes are seen by any read issued after their last W beat is accepted
`timescale 1ns/1ns
`default_nettype none

module axi_mem_top
	import axi_mem_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              resetn,
	input  wire logic              awvalid,
	output logic                   awready,
	input  wire logic [ADDR_W-1:0] awaddr,
	input  wire logic [2:0]        awsize,
	input  wire logic [1:0]        awburst,
	input  wire axi_id_t           awid,
	input  wire axi_len_t          awlen,
	input  wire logic              wvalid,
	output logic                   wready,
	input  wire logic              wlast,
	input  wire axi_data_t         wdata,
	input  wire axi_strb_t         wstrb,
	input  wire axi_id_t           wid,
	input  wire logic              arvalid,
	output logic                   arready,
	input  wire logic [ADDR_W-1:0] araddr,
	input  wire logic [2:0]        arsize,
	input  wire logic [1:0]        arburst,
	input  wire axi_id_t           arid,
	input  wire axi_len_t          arlen,
	output logic                   rvalid,
	input  wire logic              rready,
	output logic                   rlast,
	output axi_data_t              rdata,
	output logic [1:0]             rresp,
	output axi_id_t                rid
);

	// ------------------------------------------------------------
	// FIFO nets
	// ------------------------------------------------------------
	logic   aw_cntl_wr_req, aw_cntl_rd_req, aw_cntl_full, aw_cntl_empty;
	cntl_t  aw_cntl_wr_din, aw_cntl_dout;
	logic   ar_cntl_wr_req, ar_cntl_rd_req, ar_cntl_full, ar_cntl_empty;
	cntl_t  ar_cntl_wr_din, ar_cntl_dout;
	logic   w_data_wr_req, w_data_rd_req, w_data_full, w_data_empty;
	wbeat_t w_data_wr_din, w_data_dout;
	logic   r_data_wr_req, r_data_rd_req, r_data_full, r_data_empty;
	rbeat_t r_data_wr_din, r_data_dout;

	axi_decoder u_decoder (
		.clk, .resetn,
		.awvalid, .awready, .awaddr, .awsize, .awburst, .awid, .awlen,
		.wvalid, .wready, .wlast, .wdata, .wstrb, .wid,
		.arvalid, .arready, .araddr, .arsize, .arburst, .arid, .arlen,
		.rvalid, .rready, .rlast, .rdata, .rresp, .rid,
		.aw_cntl_wr_req, .aw_cntl_wr_din, .aw_cntl_full,
		.ar_cntl_wr_req, .ar_cntl_wr_din, .ar_cntl_full,
		.w_data_wr_req, .w_data_wr_din, .w_data_full,
		.r_data_rd_req, .r_data_rd_dout(r_data_dout), .r_data_empty
	);

	sync_fifo #(.WIDTH(CNTL_W), .DEPTH(CNTL_DEPTH)) u_aw_cntl (
		.clk, .resetn,
		.wr_req(aw_cntl_wr_req), .wr_din(aw_cntl_wr_din), .full(aw_cntl_full),
		.rd_req(aw_cntl_rd_req), .rd_dout(aw_cntl_dout), .empty(aw_cntl_empty)
	);

	sync_fifo #(.WIDTH(CNTL_W), .DEPTH(CNTL_DEPTH)) u_ar_cntl (
		.clk, .resetn,
		.wr_req(ar_cntl_wr_req), .wr_din(ar_cntl_wr_din), .full(ar_cntl_full),
		.rd_req(ar_cntl_rd_req), .rd_dout(ar_cntl_dout), .empty(ar_cntl_empty)
	);

	sync_fifo #(.WIDTH(WBEAT_W), .DEPTH(DATA_DEPTH)) u_w_data (
		.clk, .resetn,
		.wr_req(w_data_wr_req), .wr_din(w_data_wr_din), .full(w_data_full),
		.rd_req(w_data_rd_req), .rd_dout(w_data_dout), .empty(w_data_empty)
	);

	sync_fifo #(.WIDTH(RBEAT_W), .DEPTH(DATA_DEPTH)) u_r_data (
		.clk, .resetn,
		.wr_req(r_data_wr_req), .wr_din(r_data_wr_din), .full(r_data_full),
		.rd_req(r_data_rd_req), .rd_dout(r_data_dout), .empty(r_data_empty)
	);

	burst_mem_engine u_engine (
		.clk, .resetn,
		.aw_cntl_dout, .aw_cntl_empty, .aw_cntl_rd_req,
		.w_data_dout, .w_data_empty, .w_data_rd_req,
		.ar_cntl_dout, .ar_cntl_empty, .ar_cntl_rd_req,
		.r_data_wr_req, .r_data_wr_din, .r_data_full
	);

endmodule

`default_nettype wire

// ==== verilog/burst_mem_engine.sv ====
// Burst engine over a 256-word memory where writes win over reads
// Address bits above 9 are dropped, so the memory aliases
// W beats must follow AW order without interleaving
`timescale 1ns/1ns
`default_nettype none

module burst_mem_engine
	import axi_mem_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   resetn,
	input  wire cntl_t  aw_cntl_dout,
	input  wire logic   aw_cntl_empty,
	output logic        aw_cntl_rd_req,
	input  wire wbeat_t w_data_dout,
	input  wire logic   w_data_empty,
	output logic        w_data_rd_req,
	input  wire cntl_t  ar_cntl_dout,
	input  wire logic   ar_cntl_empty,
	output logic        ar_cntl_rd_req,
	output logic        r_data_wr_req,
	output rbeat_t      r_data_wr_din,
	input  wire logic   r_data_full
);

	eng_state_t state;

	// Latched request
	logic       err_q;
	axi_id_t    id_q;
	logic [1:0] burst_q;
	logic [2:0] size_q;
	axi_len_t   len_q;
	logic [15:0] addr_q;
	axi_len_t   beat_q;

	axi_data_t  mem [MEM_WORDS];
	mem_idx_t   idx;
	cntl_t      req;
	logic       rd_go;
	logic       beat_go;
	logic       last_beat;
	logic [15:0] addr_step;
	axi_data_t  rd_word;
	logic [1:0] rd_resp;

	// Write requests first; reads only when no AW is waiting
	assign aw_cntl_rd_req = (state == ENG_IDLE) && !aw_cntl_empty;
	assign ar_cntl_rd_req = (state == ENG_IDLE) && aw_cntl_empty && !ar_cntl_empty;
	assign req = aw_cntl_rd_req ? aw_cntl_dout : ar_cntl_dout;

	assign w_data_rd_req = (state == ENG_WRITE) && !w_data_empty;
	assign rd_go         = (state == ENG_READ) && !r_data_full;
	assign beat_go       = w_data_rd_req || rd_go;
	assign last_beat     = (beat_q == len_q);

	assign idx       = addr_q[9:2];
	assign addr_step = 16'd1 << size_q;    // Bytes per beat

	// ------------------------------------------------------------
	// Engine FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state  <= ENG_IDLE;
			beat_q <= '0;
		end else begin
			case (state)
				ENG_IDLE: begin
					beat_q <= '0;
					if (aw_cntl_rd_req)
						state <= ENG_WRITE;
					else if (ar_cntl_rd_req)
						state <= ENG_READ;
				end
				ENG_WRITE, ENG_READ: begin
					if (beat_go) begin
						beat_q <= beat_q + 1'b1;
						if (last_beat)
							state <= ENG_IDLE;
					end
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// Request fields and the running byte address
	always_ff @(posedge clk) begin
		if (aw_cntl_rd_req || ar_cntl_rd_req) begin
			err_q   <= req[29];
			id_q    <= req[28:25];
			burst_q <= req[24:23];
			size_q  <= req[22:20];
			len_q   <= req[19:16];
			addr_q  <= req[15:0];
		end else if (beat_go && (burst_q == BURST_INCR || burst_q == BURST_WRAP)) begin
			addr_q <= addr_q + addr_step;    // FIXED holds the address
		end
	end

	// ------------------------------------------------------------
	// Memory write with byte strobes
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (w_data_rd_req && !err_q) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (w_data_dout[DATA_W + b])
					mem[idx][8*b +: 8] <= w_data_dout[8*b +: 8];
			end
		end
	end

	// Error requests read back zero data with SLVERR
	assign rd_word = err_q ? '0 : mem[idx];
	assign rd_resp = err_q ? RESP_SLVERR : RESP_OKAY;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			r_data_wr_req <= 1'b0;
		else
			r_data_wr_req <= rd_go;
	end

	always_ff @(posedge clk) begin
		if (rd_go)
			r_data_wr_din <= {last_beat, id_q, rd_resp, rd_word};
	end

	// W stream must stay in step with the accepted AW
	a_wid_match: assert property (@(posedge clk) disable iff (!resetn)
		w_data_rd_req |-> w_data_dout[39:36] == id_q);
	a_wlast_pos: assert property (@(posedge clk) disable iff (!resetn)
		w_data_rd_req |-> w_data_dout[40] == last_beat);

endmodule

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
// First-word-fall-through FIFO whose head word is valid whenever empty is low
// full also counts a push already under way, so a producer that registers
// its push one cycle after checking full never overflows
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  wire logic             clk,
	input  wire logic             resetn,
	input  wire logic             wr_req,
	input  wire logic [WIDTH-1:0] wr_din,
	output logic                  full,
	input  wire logic             rd_req,
	output logic      [WIDTH-1:0] rd_dout,
	output logic                  empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(DEPTH)) || (count == CNT_W'(DEPTH - 1) && wr_req);
	assign rd_dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_req)
			mem[wr_ptr] <= wr_din;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_req)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_req)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_req && !rd_req)
				count <= count + 1'b1;
			else if (rd_req && !wr_req)
				count <= count - 1'b1;
		end
	end

	// Strobes must respect the flags
	a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
		wr_req |-> count != CNT_W'(DEPTH));
	a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
		rd_req |-> count != '0);

endmodule

`default_nettype wire
